// ==== testbench/fetch_golden.txt ====
# W addr data strb | R addr | H cycles | J after_pc flags(jal,branch,jalr,trap) alu me_pc imm r1 mtvec
# E pc inst in fetch order | D rdata in load order | all numbers hex
W 100 c0de0104c0de0100 ff
W 108 c0de010cc0de0108 ff
W 110 c0de0114c0de0110 ff
W 128 c0de012cc0de0128 ff
W 130 c0de0134c0de0130 ff
W 138 c0de013cc0de0138 ff
W 600 1122334455667788 ff
W 600 aabbccddeeff0011 0f
W 608 0123456789abcdef ff
W 608 fedcba9876543210 c3
E 100 c0de0100
E 104 c0de0104
E 108 c0de0108
E 10c c0de010c
J 10c 8 0 10c 1c 0 0
E 128 c0de0128
E 12c c0de012c
E 130 c0de0130
E 134 c0de0134
R 600
D 11223344eeff0011
J 134 4 0 134 ffffffffffffffdc 0 0
E 110 c0de0110
J 110 4 5 110 40 0 0
E 114 c0de0114
J 114 2 0 0 10 129 0
E 138 c0de0138
J 138 9 0 138 ffffffffffffffcc 0 1f0
E 104 c0de0104
J 104 1 0 0 0 0 130
E 130 c0de0130
E 134 c0de0134
E 138 c0de0138
E 13c c0de013c
R 608
D fedc456789ab3210
H 10

// ==== vlog.f ====
+incdir+hdl
hdl/core_types_pkg.sv
hdl/bus_pkg.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/bus_memory.sv
hdl/fetch_subsystem_top.sv
testbench/tb_checker.sv
testbench/tb_fetch_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run from the project root, the golden file path is relative to it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_fetch_subsystem -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// ==== testbench/tb_fetch_subsystem.sv ====
`default_nettype none

module tb_fetch_subsystem;
    import core_types_pkg::*;

    logic       clk;
    logic       rst_n_i;
    logic       fetch_stall_i;
    redirect_t  redirect_i;
    logic       fetch_valid_o;
    fetch_out_t fetch_o;
    logic       lsu_valid_i;
    lsu_req_t   lsu_req_i;
    logic       lsu_busy_o;
    logic       lsu_done_o;
    xlen_t      lsu_rdata_o;
    int         fetch_errs;
    int         load_errs;
    int         fetch_left;
    int         load_left;
    int         cycles = 0;
    int         limit = 0;  // 200 cycles per golden line
    string      lines [$];

    fetch_subsystem_top fetch_subsystem_top_i (.*);

    tb_checker tb_checker_i (
        .clk, .rst_n_i, .fetch_stall_i,
        .fetch_valid_i(fetch_valid_o), .fetch_i(fetch_o),
        .lsu_valid_i, .lsu_req_i, .lsu_busy_i(lsu_busy_o),
        .lsu_done_i(lsu_done_o), .lsu_rdata_i(lsu_rdata_o),
        .fetch_errs_o(fetch_errs), .load_errs_o(load_errs),
        .fetch_left_o(fetch_left), .load_left_o(load_left)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic finish_run(input logic timed_out);
        if (fetch_left != 0 || load_left != 0) begin
            $display("expectations never met: %0d fetch, %0d load", fetch_left, load_left);
        end
        $display("errors: fetch %0d, load %0d", fetch_errs, load_errs);
        if (!timed_out && fetch_errs == 0 && load_errs == 0 && fetch_left == 0 &&
            load_left == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not complete within %0d cycles", limit);
            finish_run(1'b1);
        end
    end

    task automatic access_memory(input logic we, input addr_t addr, input xlen_t data,
                                 input logic [7:0] strb);
        while (lsu_busy_o) @(negedge clk);
        repeat ($urandom_range(3, 0)) @(negedge clk);  // idle gap
        lsu_req_i.addr  = addr;
        lsu_req_i.wdata = data;
        lsu_req_i.we    = we;
        lsu_req_i.strb  = strb;
        lsu_valid_i     = 1'b1;
        @(negedge clk);
        lsu_valid_i = 1'b0;
        while (!lsu_done_o) @(negedge clk);
    endtask

    task automatic hold_stall(input int n);
        fetch_stall_i = 1'b1;
        repeat (n) @(negedge clk);
        fetch_stall_i = 1'b0;
    endtask

    // one cycle of redirect right after the matching delivery
    task automatic pulse_redirect(input addr_t after_pc, input logic [3:0] flags,
                                  input xlen_t alu, input addr_t me_pc, input xlen_t imm,
                                  input xlen_t r1, input addr_t mtvec);
        while (!(fetch_valid_o && fetch_o.pc == after_pc)) @(negedge clk);
        redirect_i.jal     = flags[3];
        redirect_i.branch  = flags[2];
        redirect_i.jalr    = flags[1];
        redirect_i.trap    = flags[0];
        redirect_i.alu_res = alu;
        redirect_i.me_pc   = me_pc;
        redirect_i.me_imm  = imm;
        redirect_i.r1_data = r1;
        redirect_i.mtvec   = mtvec;
        @(negedge clk);
        redirect_i = '0;
    endtask

    task automatic run_command(input string line);
        logic [7:0]  kind;
        logic [63:0] v0, v1, v2, v3, v4, v5, v6;
        kind = line.getc(0);
        {v0, v1, v2, v3, v4, v5, v6} = '0;
        if (line.len() > 1) begin
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                          v0, v1, v2, v3, v4, v5, v6));
        end
        // the first non-store command ends the program load
        if (kind == "R" || kind == "J") fetch_stall_i = 1'b0;
        case (kind)
            "W": access_memory(1'b1, v0, v1, v2[7:0]);
            "R": access_memory(1'b0, v0, '0, 8'hff);
            "H": hold_stall(int'(v0));
            "J": pulse_redirect(v0, v1[3:0], v2, v3, v4, v5, v6);
            default: ;  // expectation and comment lines
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        void'($urandom(32'h030f_eeb9));
        rst_n_i       = 1'b0;
        fetch_stall_i = 1'b1;  // held while the program is stored
        redirect_i    = '0;
        lsu_valid_i   = 1'b0;
        lsu_req_i     = '0;
        fd = $fopen("testbench/fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file testbench/fetch_golden.txt could not be opened");
            finish_run(1'b1);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) lines.push_back(line);
            end
            $fclose(fd);
            limit = 200 * lines.size();
            repeat (5) @(negedge clk);
            rst_n_i = 1'b1;
            foreach (lines[i]) run_command(lines[i]);
            while (fetch_left != 0 || load_left != 0) @(posedge clk);
            finish_run(1'b0);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_checker.sv ====
`default_nettype none

module tb_checker (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       fetch_stall_i,
    input  logic                       fetch_valid_i,
    input  core_types_pkg::fetch_out_t fetch_i,
    input  logic                       lsu_valid_i,
    input  core_types_pkg::lsu_req_t   lsu_req_i,
    input  logic                       lsu_busy_i,
    input  logic                       lsu_done_i,
    input  core_types_pkg::xlen_t      lsu_rdata_i,
    output int                         fetch_errs_o,
    output int                         load_errs_o,
    output int                         fetch_left_o,
    output int                         load_left_o
);
    import core_types_pkg::*;

    addr_t exp_pc [$];
    inst_t exp_inst [$];
    xlen_t exp_rdata [$];
    logic  stall_q;   // stall as seen by the response that fed this delivery
    logic  load_q;    // access in flight is a load
    logic  busy_exp;  // rises after an accepted access, drops when done ends

    initial begin
        int          fd;
        string       line;
        logic [63:0] a;
        logic [63:0] b;
        fetch_errs_o = 0;
        load_errs_o  = 0;
        fd = $fopen("testbench/fetch_golden.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 1) begin
                a = '0;
                b = '0;
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                if (line.getc(0) == "E") begin
                    exp_pc.push_back(a);
                    exp_inst.push_back(b[31:0]);
                end else if (line.getc(0) == "D") begin
                    exp_rdata.push_back(a);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        fetch_left_o = exp_pc.size();
        load_left_o  = exp_rdata.size();
    end

    always @(posedge clk) begin
        stall_q <= fetch_stall_i;
        if (!rst_n_i) begin
            load_q   <= 1'b0;
            busy_exp <= 1'b0;
        end else if (lsu_valid_i && !busy_exp) begin
            load_q   <= !lsu_req_i.we;
            busy_exp <= 1'b1;
        end else if (lsu_done_i) begin
            busy_exp <= 1'b0;
        end
    end

    // outputs settle at the rising edge and are compared half a cycle later
    always @(negedge clk) begin
        if (rst_n_i && fetch_valid_i) begin
            if (exp_pc.size() == 0) begin
                $display("error at %0t: fetch of pc %h with no expectation left", $time,
                         fetch_i.pc);
                fetch_errs_o++;
            end else if (stall_q) begin
                // the instruction may predate the stored program while the pc is held
                if (fetch_i.pc != exp_pc[0]) begin
                    $display("error at %0t: stalled fetch pc %h, expected %h", $time,
                             fetch_i.pc, exp_pc[0]);
                    fetch_errs_o++;
                end
            end else begin
                if (fetch_i.pc != exp_pc[0] || fetch_i.inst != exp_inst[0]) begin
                    $display("error at %0t: fetch pc %h inst %h, expected pc %h inst %h",
                             $time, fetch_i.pc, fetch_i.inst, exp_pc[0], exp_inst[0]);
                    fetch_errs_o++;
                end
                void'(exp_pc.pop_front());
                void'(exp_inst.pop_front());
                fetch_left_o = exp_pc.size();
            end
        end
        if (rst_n_i && lsu_busy_i != busy_exp) begin
            $display("error at %0t: lsu busy %b, expected %b", $time, lsu_busy_i, busy_exp);
            load_errs_o++;
        end
        if (rst_n_i && lsu_done_i && load_q) begin
            if (exp_rdata.size() == 0) begin
                $display("error at %0t: load data %h with no expectation left", $time,
                         lsu_rdata_i);
                load_errs_o++;
            end else begin
                if (lsu_rdata_i != exp_rdata[0]) begin
                    $display("error at %0t: load data %h, expected %h", $time, lsu_rdata_i,
                             exp_rdata[0]);
                    load_errs_o++;
                end
                void'(exp_rdata.pop_front());
                load_left_o = exp_rdata.size();
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_subsystem_top.sv ====
`default_nettype none

module fetch_subsystem_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       fetch_stall_i,
    input  core_types_pkg::redirect_t  redirect_i,
    output logic                       fetch_valid_o,
    output core_types_pkg::fetch_out_t fetch_o,
    input  logic                       lsu_valid_i,
    input  core_types_pkg::lsu_req_t   lsu_req_i,
    output logic                       lsu_busy_o,
    output logic                       lsu_done_o,
    output core_types_pkg::xlen_t      lsu_rdata_o
);
    import bus_pkg::*;

    // f_ fetch side, d_ data side, m_ memory side
    logic     f_req_valid, f_req_ready, f_rsp_valid, f_rsp_ready;
    logic     d_req_valid, d_req_ready, d_rsp_valid, d_rsp_ready;
    logic     m_req_valid, m_req_ready, m_rsp_valid, m_rsp_ready;
    bus_req_t f_req, d_req, m_req;
    bus_rsp_t f_rsp, d_rsp, m_rsp;

    fetch_unit fetch_unit_i (
        .clk, .rst_n_i, .fetch_stall_i, .redirect_i,
        .req_valid_o(f_req_valid), .req_ready_i(f_req_ready), .req_o(f_req),
        .rsp_valid_i(f_rsp_valid), .rsp_ready_o(f_rsp_ready), .rsp_i(f_rsp),
        .fetch_valid_o, .fetch_o
    );

    load_store_unit load_store_unit_i (
        .clk, .rst_n_i, .lsu_valid_i, .lsu_req_i, .lsu_busy_o, .lsu_done_o, .lsu_rdata_o,
        .req_valid_o(d_req_valid), .req_ready_i(d_req_ready), .req_o(d_req),
        .rsp_valid_i(d_rsp_valid), .rsp_ready_o(d_rsp_ready), .rsp_i(d_rsp)
    );

    mem_arbiter mem_arbiter_i (
        .clk, .rst_n_i,
        .f_req_valid_i(f_req_valid), .f_req_ready_o(f_req_ready), .f_req_i(f_req),
        .f_rsp_valid_o(f_rsp_valid), .f_rsp_ready_i(f_rsp_ready), .f_rsp_o(f_rsp),
        .d_req_valid_i(d_req_valid), .d_req_ready_o(d_req_ready), .d_req_i(d_req),
        .d_rsp_valid_o(d_rsp_valid), .d_rsp_ready_i(d_rsp_ready), .d_rsp_o(d_rsp),
        .m_req_valid_o(m_req_valid), .m_req_ready_i(m_req_ready), .m_req_o(m_req),
        .m_rsp_valid_i(m_rsp_valid), .m_rsp_ready_o(m_rsp_ready), .m_rsp_i(m_rsp)
    );

    bus_memory bus_memory_i (
        .clk, .rst_n_i,
        .req_valid_i(m_req_valid), .req_ready_o(m_req_ready), .req_i(m_req),
        .rsp_valid_o(m_rsp_valid), .rsp_ready_i(m_rsp_ready), .rsp_o(m_rsp)
    );

endmodule

`default_nettype wire

// ==== hdl/bus_memory.sv ====
`default_nettype none
`include "fetch_cfg.svh"

module bus_memory (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  bus_pkg::bus_req_t req_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output bus_pkg::bus_rsp_t rsp_o
);
    import core_types_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    xlen_t             mem_q [`MEM_WORDS];
    logic [IDX_W-1:0]  req_idx;  // word index, bits above the byte offset
    logic [CNT_W-1:0]  cnt_q;
    logic              pend_q;
    logic              accept;
    addr_t             addr_q;
    xlen_t             rdata_q;

    assign req_ready_o = !pend_q;
    assign accept      = req_valid_i && req_ready_o;
    assign req_idx     = req_i.addr[IDX_W+2:3];

    assign rsp_o.addr  = addr_q;  // echoed for the stale check in fetch
    assign rsp_o.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_q      <= 1'b0;
            rsp_valid_o <= 1'b0;
            cnt_q       <= '0;
        end else if (accept) begin
            pend_q <= 1'b1;
            cnt_q  <= CNT_W'(`MEM_LATENCY - 1);
        end else if (rsp_valid_o) begin
            if (rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
                pend_q      <= 1'b0;
            end
        end else if (pend_q) begin
            if (cnt_q == '0) rsp_valid_o <= 1'b1;
            else cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_i.addr;
            rdata_q <= mem_q[req_idx];  // word before any write below
            if (req_i.we) begin
                for (int b = 0; b < 8; b++) begin
                    if (req_i.strb[b]) mem_q[req_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    rsp_needs_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o |-> pend_q && $past(pend_q))
        else $error("memory response without a pending request");

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              f_req_valid_i,
    output logic              f_req_ready_o,
    input  bus_pkg::bus_req_t f_req_i,
    output logic              f_rsp_valid_o,
    input  logic              f_rsp_ready_i,
    output bus_pkg::bus_rsp_t f_rsp_o,
    input  logic              d_req_valid_i,
    output logic              d_req_ready_o,
    input  bus_pkg::bus_req_t d_req_i,
    output logic              d_rsp_valid_o,
    input  logic              d_rsp_ready_i,
    output bus_pkg::bus_rsp_t d_rsp_o,
    output logic              m_req_valid_o,
    input  logic              m_req_ready_i,
    output bus_pkg::bus_req_t m_req_o,
    input  logic              m_rsp_valid_i,
    output logic              m_rsp_ready_o,
    input  bus_pkg::bus_rsp_t m_rsp_i
);
    import bus_pkg::*;

    arb_state_e state_q;
    logic       last_data_q;  // data side won the previous grant
    logic       grant_f;
    logic       grant_d;

    // decided only in IDLE and then held until the response
    always_comb begin
        grant_f = 1'b0;
        grant_d = 1'b0;
        if (state_q == IDLE) begin
            if (f_req_valid_i && d_req_valid_i) begin
                grant_f = last_data_q;
                grant_d = !last_data_q;
            end else begin
                grant_f = f_req_valid_i;
                grant_d = d_req_valid_i;
            end
        end
    end

    assign m_req_valid_o = grant_f || grant_d;
    assign m_req_o       = grant_d ? d_req_i : f_req_i;
    assign f_req_ready_o = grant_f && m_req_ready_i;
    assign d_req_ready_o = grant_d && m_req_ready_i;

    // response goes straight back to the owner
    assign f_rsp_valid_o = (state_q == BUSY_FETCH) && m_rsp_valid_i;
    assign d_rsp_valid_o = (state_q == BUSY_DATA) && m_rsp_valid_i;
    assign f_rsp_o       = m_rsp_i;
    assign d_rsp_o       = m_rsp_i;
    assign m_rsp_ready_o = (state_q == BUSY_FETCH) ? f_rsp_ready_i :
                           (state_q == BUSY_DATA)  ? d_rsp_ready_i : 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            last_data_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (m_req_valid_o && m_req_ready_i) begin
                    state_q     <= grant_d ? BUSY_DATA : BUSY_FETCH;
                    last_data_q <= grant_d;
                end
                BUSY_FETCH, BUSY_DATA: if (m_rsp_valid_i && m_rsp_ready_o) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    one_grant: assert property (@(posedge clk) disable iff (!rst_n_i) !(grant_f && grant_d))
        else $error("both requesters granted");

    // memory must be free again by the time the arbiter is back in IDLE
    no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_req_valid_o |-> m_req_ready_i)
        else $error("memory request while a transaction is open");

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`default_nettype none

module load_store_unit (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     lsu_valid_i,
    input  core_types_pkg::lsu_req_t lsu_req_i,
    output logic                     lsu_busy_o,
    output logic                     lsu_done_o,
    output core_types_pkg::xlen_t    lsu_rdata_o,
    output logic                     req_valid_o,
    input  logic                     req_ready_i,
    output bus_pkg::bus_req_t        req_o,
    input  logic                     rsp_valid_i,
    output logic                     rsp_ready_o,
    input  bus_pkg::bus_rsp_t        rsp_i
);
    import core_types_pkg::*;

    typedef enum logic [1:0] {
        LS_IDLE,
        LS_REQ,
        LS_WAIT
    } ls_state_e;

    ls_state_e state_q;
    lsu_req_t  acc_q;  // access being served
    logic      accept;
    logic      rsp_fire;

    assign rsp_ready_o = 1'b1;
    assign rsp_fire    = rsp_valid_i && rsp_ready_o;
    assign accept      = (state_q == LS_IDLE) && !lsu_busy_o && lsu_valid_i;

    assign req_valid_o = (state_q == LS_REQ);
    assign req_o.addr  = acc_q.addr;
    assign req_o.wdata = acc_q.wdata;
    assign req_o.we    = acc_q.we;
    assign req_o.strb  = acc_q.strb;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= LS_IDLE;
            lsu_busy_o <= 1'b0;
            lsu_done_o <= 1'b0;
        end else begin
            lsu_done_o <= 1'b0;
            case (state_q)
                LS_IDLE: if (accept) begin
                    state_q    <= LS_REQ;
                    lsu_busy_o <= 1'b1;
                end
                LS_REQ: if (req_ready_i) state_q <= LS_WAIT;
                LS_WAIT: if (rsp_fire) begin
                    lsu_done_o <= 1'b1;  // stores pulse done as well
                    state_q    <= LS_IDLE;
                end
                default: state_q <= LS_IDLE;
            endcase
            if (lsu_done_o) lsu_busy_o <= 1'b0;  // busy ends together with done
        end
    end

    always_ff @(posedge clk) begin
        if (accept) acc_q <= lsu_req_i;
        if (state_q == LS_WAIT && rsp_fire) lsu_rdata_o <= rsp_i.rdata;
    end

    done_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        lsu_done_o |-> lsu_busy_o)
        else $error("lsu done pulsed while not busy");

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`default_nettype none
`include "fetch_cfg.svh"

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      fetch_stall_i,
    input  core_types_pkg::redirect_t redirect_i,
    output logic                      req_valid_o,
    input  logic                      req_ready_i,
    output bus_pkg::bus_req_t         req_o,
    input  logic                      rsp_valid_i,
    output logic                      rsp_ready_o,
    input  bus_pkg::bus_rsp_t         rsp_i,
    output logic                      fetch_valid_o,
    output core_types_pkg::fetch_out_t fetch_o
);
    import core_types_pkg::*;

    addr_t pc_q;
    addr_t pc_next;
    addr_t req_addr_q;  // address of the request in flight
    addr_t jalr_sum;
    inst_t rsp_inst;
    logic  pend_q;      // accepted, waiting for response
    logic  rsp_fire;
    logic  redirect_hit;
    logic  rsp_match;

    assign rsp_ready_o = 1'b1;
    assign rsp_fire    = rsp_valid_i && rsp_ready_o;

    assign redirect_hit = redirect_i.jal || (redirect_i.branch && redirect_i.alu_res == '0) ||
                          redirect_i.jalr || redirect_i.trap;

    // a response for an older pc, or one racing a redirect, is dropped
    assign rsp_match = rsp_fire && (rsp_i.addr == pc_q) && !redirect_hit;

    assign jalr_sum = redirect_i.r1_data + redirect_i.me_imm;
    assign rsp_inst = rsp_i.addr[2] ? rsp_i.rdata[63:32] : rsp_i.rdata[31:0];

    always_comb begin
        if (redirect_i.jal || (redirect_i.branch && redirect_i.alu_res == '0)) begin
            pc_next = redirect_i.me_pc + redirect_i.me_imm;
        end else if (redirect_i.jalr) begin
            pc_next = {jalr_sum[63:1], 1'b0};  // jalr drops bit 0
        end else if (redirect_i.trap) begin
            pc_next = redirect_i.mtvec;
        end else if (rsp_match && !fetch_stall_i) begin
            pc_next = pc_q + 64'd4;
        end else begin
            pc_next = pc_q;  // stalled, or still waiting
        end
    end

    assign req_o.addr  = req_addr_q;
    assign req_o.wdata = '0;
    assign req_o.we    = 1'b0;
    assign req_o.strb  = req_addr_q[2] ? 8'hf0 : 8'h0f;  // the half holding the inst

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q          <= addr_t'(`FETCH_RESET_PC);
            req_valid_o   <= 1'b0;
            pend_q        <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            pc_q          <= pc_next;
            fetch_valid_o <= rsp_match;
            if (req_valid_o) begin
                if (req_ready_i) begin
                    req_valid_o <= 1'b0;
                    pend_q      <= 1'b1;
                end
            end else if (rsp_fire || !pend_q) begin
                // next request goes out at the pc that is just being set
                req_valid_o <= 1'b1;
                pend_q      <= 1'b0;
                req_addr_q  <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_match) begin
            fetch_o.pc   <= pc_q;
            fetch_o.inst <= rsp_inst;
        end
    end

    // redirect targets from the later stages must stay halfword aligned
    pc_bit0_clear: assert property (@(posedge clk) disable iff (!rst_n_i) pc_q[0] == 1'b0)
        else $error("fetch pc has bit 0 set");

endmodule

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    typedef logic [7:0] bus_strb_t;  // one bit per byte lane

    typedef struct packed {
        core_types_pkg::addr_t addr;
        core_types_pkg::xlen_t wdata;
        logic                  we;
        bus_strb_t             strb;
    } bus_req_t;

    // address comes back with the data
    // fetch uses it to spot responses for an old pc
    typedef struct packed {
        core_types_pkg::addr_t addr;
        core_types_pkg::xlen_t rdata;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY_FETCH,
        BUSY_DATA
    } arb_state_e;

endpackage

`default_nettype wire

// ==== hdl/core_types_pkg.sv ====
`default_nettype none

package core_types_pkg;

    typedef logic [63:0] xlen_t;  // one data word
    typedef logic [63:0] addr_t;  // byte address
    typedef logic [31:0] inst_t;  // one rv instruction

    // late-stage pc control, sampled by fetch every cycle
    typedef struct packed {
        logic  jal;
        logic  branch;
        logic  jalr;
        logic  trap;
        xlen_t alu_res;  // branch taken when zero
        addr_t me_pc;
        xlen_t me_imm;
        xlen_t r1_data;
        addr_t mtvec;
    } redirect_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_out_t;

    typedef struct packed {
        addr_t       addr;
        xlen_t       wdata;
        logic        we;
        logic [7:0]  strb;  // byte enables
    } lsu_req_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address after reset, widened into the 64-bit pc space
`define FETCH_RESET_PC 32'h0000_0100

// depth of the shared memory in 64-bit words
`define MEM_WORDS 256

// cycles from request acceptance to rsp_valid
`define MEM_LATENCY 2

`endif
